//--- hw/vdiv_pkg.sv
//***********************************************************
// Shared widths, lane count and the half-precision word type
// for the vector divide unit. Files refer to these items by
// scoped names.
//***********************************************************
package vdiv_pkg;

    // Half-precision format
    localparam int EXP_WIDTH  = 5;
    localparam int MANT_WIDTH = 10;
    localparam int FP_WIDTH   = 1 + EXP_WIDTH + MANT_WIDTH;

    // Quotient carries two extra bits for normalization plus one round bit
    localparam int QUOT_WIDTH = MANT_WIDTH + 3;

    // Divider step counter, counts 0 to QUOT_WIDTH-1
    localparam int DIV_COUNT_WIDTH = $clog2(QUOT_WIDTH);

    // Signed exponent math needs two guard bits
    localparam logic signed [EXP_WIDTH+1:0] EXP_BIAS = 15;
    localparam logic signed [EXP_WIDTH+1:0] EXP_INF  = 31;

    // Vector unit organization
    localparam int NUM_LANES      = 2;
    localparam int LANE_IDX_WIDTH = $clog2(NUM_LANES);
    localparam int TAG_WIDTH      = 4;

    typedef struct packed {
        logic                  sign;
        logic [EXP_WIDTH-1:0]  exp;
        logic [MANT_WIDTH-1:0] mant;
    } fp_fields_t;

    // One word seen either as raw bits or as IEEE fields
    typedef union packed {
        logic [FP_WIDTH-1:0] bits;
        fp_fields_t          fields;
    } fp_word_t;

endpackage

//--- hw/mant_divider.sv
//***********************************************************
// Restoring mantissa divider, one quotient bit per cycle.
// Pulse en to load x and y; result equals x*2^12/y (integer
// part) once done pulses, QUOT_WIDTH cycles later.
//***********************************************************
`timescale 1ns/1ns

module mant_divider (
    input  logic                            CLK,
    input  logic                            nRST,
    input  logic                            en,
    input  logic [vdiv_pkg::MANT_WIDTH:0]   x,
    input  logic [vdiv_pkg::MANT_WIDTH:0]   y,
    output logic [vdiv_pkg::QUOT_WIDTH-1:0] result,
    output logic                            done
);

    logic                                 busy;
    logic [vdiv_pkg::DIV_COUNT_WIDTH-1:0] count;
    logic [vdiv_pkg::MANT_WIDTH+1:0]      rem;
    logic [vdiv_pkg::MANT_WIDTH:0]        divisor;
    logic [vdiv_pkg::QUOT_WIDTH-1:0]      quot;
    logic [vdiv_pkg::MANT_WIDTH+2:0]      diff;
    logic                                 ge;

    // Trial subtraction, top bit is the borrow
    assign diff = {1'b0, rem} - {2'b00, divisor};
    assign ge   = ~diff[vdiv_pkg::MANT_WIDTH+2];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            busy  <= 1'b0;
            count <= '0;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            if (en) begin
                busy  <= 1'b1;
                count <= '0;
            end else if (busy) begin
                count <= count + 1'b1;
                if (count == vdiv_pkg::QUOT_WIDTH - 1) begin
                    busy <= 1'b0;
                    done <= 1'b1;
                end
            end
        end
    end

    // Remainder stays below 2*y, so it fits in MANT_WIDTH+2 bits
    always_ff @(posedge CLK) begin
        if (en) begin
            rem     <= {1'b0, x};
            divisor <= y;
        end else if (busy) begin
            quot <= {quot[vdiv_pkg::QUOT_WIDTH-2:0], ge};
            if (ge)
                rem <= {diff[vdiv_pkg::MANT_WIDTH:0], 1'b0};
            else
                rem <= {rem[vdiv_pkg::MANT_WIDTH:0], 1'b0};
        end
    end

    assign result = quot;

endmodule

//--- hw/fp_div.sv
//***********************************************************
// One half-precision divide lane with valid/ready on both
// sides. Special operands finish at once; all others run the
// iterative mantissa divider. Subnormals flush to zero.
//***********************************************************
`timescale 1ns/1ns

module fp_div (
    input  logic               CLK,
    input  logic               nRST,
    input  logic               valid_in,
    output logic               ready_in,
    input  vdiv_pkg::fp_word_t operand1,
    input  vdiv_pkg::fp_word_t operand2,
    output logic               valid_out,
    input  logic               ready_out,
    output vdiv_pkg::fp_word_t result
);

    logic accept;
    logic out_fire;
    logic first_cycle;
    logic done;

    logic a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    logic is_nan, is_inf, is_zero, skip;
    logic final_sign;

    logic signed [vdiv_pkg::EXP_WIDTH+1:0] exp_diff;
    logic signed [vdiv_pkg::EXP_WIDTH+1:0] exp_q;
    logic signed [vdiv_pkg::EXP_WIDTH+1:0] exp_norm;
    logic signed [vdiv_pkg::EXP_WIDTH+1:0] exp_final;
    logic                                  sign_q;

    logic [vdiv_pkg::QUOT_WIDTH-1:0] quotient;
    logic [vdiv_pkg::MANT_WIDTH-1:0] mant_sel;
    logic                            round_bit;
    logic [vdiv_pkg::MANT_WIDTH:0]   mant_round;
    logic                            is_ovf, is_sub;

    vdiv_pkg::fp_word_t special_word;
    vdiv_pkg::fp_word_t div_word;

    assign accept   = valid_in && ready_in;
    assign out_fire = valid_out && ready_out;

    // Exponent zero covers both zero and subnormal
    assign a_zero = (operand1.fields.exp == '0);
    assign b_zero = (operand2.fields.exp == '0);
    assign a_inf  = (&operand1.fields.exp) && (operand1.fields.mant == '0);
    assign b_inf  = (&operand2.fields.exp) && (operand2.fields.mant == '0);
    assign a_nan  = (&operand1.fields.exp) && (operand1.fields.mant != '0);
    assign b_nan  = (&operand2.fields.exp) && (operand2.fields.mant != '0);

    assign is_nan  = a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf);
    assign is_inf  = !is_nan && (a_inf || b_zero);
    assign is_zero = !is_nan && !is_inf && (a_zero || b_inf);
    assign skip    = is_nan || is_inf || is_zero;

    assign final_sign = operand1.fields.sign ^ operand2.fields.sign;
    assign exp_diff   = $signed({2'b00, operand1.fields.exp})
                      - $signed({2'b00, operand2.fields.exp}) + vdiv_pkg::EXP_BIAS;

    // Only normal operands reach here, so the hidden bit is always one
    mant_divider divider (
        .CLK   (CLK),
        .nRST  (nRST),
        .en    (accept && !skip),
        .x     ({1'b1, operand1.fields.mant}),
        .y     ({1'b1, operand2.fields.mant}),
        .result(quotient),
        .done  (done)
    );

    // Quotient lies in (0.5, 2); top bit picks the binary point
    always_comb begin
        if (quotient[vdiv_pkg::QUOT_WIDTH-1]) begin
            mant_sel  = quotient[vdiv_pkg::QUOT_WIDTH-2:2];
            round_bit = quotient[1];
            exp_norm  = exp_q;
        end else begin
            mant_sel  = quotient[vdiv_pkg::QUOT_WIDTH-3:1];
            round_bit = quotient[0];
            exp_norm  = exp_q - 1'b1;
        end
    end

    // A round carry out of the mantissa bumps the exponent
    assign mant_round = {1'b0, mant_sel} + {{vdiv_pkg::MANT_WIDTH{1'b0}}, round_bit};
    assign exp_final  = exp_norm
                      + {{(vdiv_pkg::EXP_WIDTH+1){1'b0}}, mant_round[vdiv_pkg::MANT_WIDTH]};
    assign is_ovf     = (exp_final >= vdiv_pkg::EXP_INF);
    assign is_sub     = exp_final[vdiv_pkg::EXP_WIDTH+1] || (exp_final == '0);

    always_comb begin
        div_word.fields.sign = sign_q;
        if (is_ovf) begin
            div_word.fields.exp  = '1;
            div_word.fields.mant = '0;
        end else if (is_sub) begin
            div_word.fields.exp  = '0;
            div_word.fields.mant = '0;
        end else begin
            div_word.fields.exp  = exp_final[vdiv_pkg::EXP_WIDTH-1:0];
            div_word.fields.mant = mant_round[vdiv_pkg::MANT_WIDTH-1:0];
        end
    end

    // Canonical NaN is quiet with only the top mantissa bit set
    always_comb begin
        special_word.fields.sign = final_sign;
        if (is_nan) begin
            special_word.fields.exp  = '1;
            special_word.fields.mant = {1'b1, {(vdiv_pkg::MANT_WIDTH-1){1'b0}}};
        end else if (is_inf) begin
            special_word.fields.exp  = '1;
            special_word.fields.mant = '0;
        end else begin
            special_word.fields.exp  = '0;
            special_word.fields.mant = '0;
        end
    end

    always_ff @(posedge CLK) begin
        if (accept) begin
            sign_q <= final_sign;
            exp_q  <= exp_diff;
            if (skip)
                result <= special_word;
        end else if (done) begin
            result <= div_word;
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            valid_out   <= 1'b0;
            ready_in    <= 1'b0;
            first_cycle <= 1'b1;
        end else begin
            first_cycle <= 1'b0;
            if (done || (accept && skip))
                valid_out <= 1'b1;
            else if (out_fire)
                valid_out <= 1'b0;
            if (first_cycle || out_fire)
                ready_in <= 1'b1;
            else if (accept)
                ready_in <= 1'b0;
        end
    end

endmodule

//--- hw/lane_dispatch.sv
//***********************************************************
// Request dispatcher for the divide lanes. Sends each element
// to the lowest-numbered free lane and keeps that element's
// tag until the lane writes back.
//***********************************************************
`timescale 1ns/1ns

module lane_dispatch (
    input  logic                                                    CLK,
    input  logic                                                    nRST,
    input  logic                                                    req_valid,
    output logic                                                    req_ready,
    input  logic [vdiv_pkg::TAG_WIDTH-1:0]                          req_tag,
    output logic [vdiv_pkg::NUM_LANES-1:0]                          lane_valid,
    input  logic [vdiv_pkg::NUM_LANES-1:0]                          lane_ready,
    output logic [vdiv_pkg::NUM_LANES-1:0][vdiv_pkg::TAG_WIDTH-1:0] lane_tag
);

    logic [vdiv_pkg::NUM_LANES-1:0] pick;

    // Isolate the lowest set bit of the ready mask
    assign pick = lane_ready & (~lane_ready + 1'b1);

    // Valid only goes to a ready lane, so every raise is a transfer
    assign lane_valid = pick & {vdiv_pkg::NUM_LANES{req_valid}};
    assign req_ready  = |lane_ready;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            lane_tag <= '0;
        end else begin
            for (int i = 0; i < vdiv_pkg::NUM_LANES; i++) begin
                if (lane_valid[i] && lane_ready[i])
                    lane_tag[i] <= req_tag;
            end
        end
    end

endmodule

//--- hw/wb_arbiter.sv
//***********************************************************
// Round-robin writeback arbiter for the shared result bus.
// Search starts after the last lane served; a stalled grant
// stays locked until the result bus accepts it.
//***********************************************************
`timescale 1ns/1ns

module wb_arbiter (
    input  logic                                                    CLK,
    input  logic                                                    nRST,
    input  logic [vdiv_pkg::NUM_LANES-1:0]                          lane_valid_out,
    output logic [vdiv_pkg::NUM_LANES-1:0]                          lane_ready_out,
    input  vdiv_pkg::fp_word_t [vdiv_pkg::NUM_LANES-1:0]            lane_result,
    input  logic [vdiv_pkg::NUM_LANES-1:0][vdiv_pkg::TAG_WIDTH-1:0] lane_tag,
    output logic                                                    res_valid,
    input  logic                                                    res_ready,
    output logic [vdiv_pkg::TAG_WIDTH-1:0]                          res_tag,
    output vdiv_pkg::fp_word_t                                      res_data
);

    logic [vdiv_pkg::LANE_IDX_WIDTH-1:0] last_q;
    logic [vdiv_pkg::LANE_IDX_WIDTH-1:0] lock_idx;
    logic [vdiv_pkg::LANE_IDX_WIDTH-1:0] pick_idx;
    logic [vdiv_pkg::LANE_IDX_WIDTH-1:0] grant_idx;
    logic                                lock_q;
    logic                                pick_found;
    int                                  cand;

    // With no lane valid the pick falls back to last_q, which is idle
    always_comb begin
        pick_idx   = last_q;
        pick_found = 1'b0;
        cand       = 0;
        for (int k = 1; k <= vdiv_pkg::NUM_LANES; k++) begin
            cand = (int'(last_q) + k) % vdiv_pkg::NUM_LANES;
            if (!pick_found && lane_valid_out[cand]) begin
                pick_idx   = cand[vdiv_pkg::LANE_IDX_WIDTH-1:0];
                pick_found = 1'b1;
            end
        end
    end

    assign grant_idx = lock_q ? lock_idx : pick_idx;
    assign res_valid = lane_valid_out[grant_idx];
    assign res_data  = lane_result[grant_idx];
    assign res_tag   = lane_tag[grant_idx];

    always_comb begin
        lane_ready_out            = '0;
        lane_ready_out[grant_idx] = res_ready;
    end

    // Reset points at the last lane so lane 0 is served first
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            last_q   <= vdiv_pkg::LANE_IDX_WIDTH'(vdiv_pkg::NUM_LANES - 1);
            lock_q   <= 1'b0;
            lock_idx <= '0;
        end else if (res_valid && res_ready) begin
            last_q <= grant_idx;
            lock_q <= 1'b0;
        end else if (res_valid) begin
            lock_q   <= 1'b1;
            lock_idx <= grant_idx;
        end
    end

endmodule

//--- hw/vdiv_unit.sv
//***********************************************************
// Half-precision vector divide functional unit. Elements come
// in with a tag on the request port; results return on one
// result bus, possibly out of order, marked by res_tag.
//***********************************************************
`timescale 1ns/1ns

module vdiv_unit (
    input  logic                           CLK,
    input  logic                           nRST,
    input  logic                           req_valid,
    output logic                           req_ready,
    input  logic [vdiv_pkg::TAG_WIDTH-1:0] req_tag,
    input  vdiv_pkg::fp_word_t             req_a,
    input  vdiv_pkg::fp_word_t             req_b,
    output logic                           res_valid,
    input  logic                           res_ready,
    output logic [vdiv_pkg::TAG_WIDTH-1:0] res_tag,
    output vdiv_pkg::fp_word_t             res_data
);

    logic [vdiv_pkg::NUM_LANES-1:0]                          lane_valid;
    logic [vdiv_pkg::NUM_LANES-1:0]                          lane_ready;
    logic [vdiv_pkg::NUM_LANES-1:0]                          lane_valid_out;
    logic [vdiv_pkg::NUM_LANES-1:0]                          lane_ready_out;
    logic [vdiv_pkg::NUM_LANES-1:0][vdiv_pkg::TAG_WIDTH-1:0] lane_tag;
    vdiv_pkg::fp_word_t [vdiv_pkg::NUM_LANES-1:0]            lane_result;

    lane_dispatch dispatch (
        .CLK       (CLK),
        .nRST      (nRST),
        .req_valid (req_valid),
        .req_ready (req_ready),
        .req_tag   (req_tag),
        .lane_valid(lane_valid),
        .lane_ready(lane_ready),
        .lane_tag  (lane_tag)
    );

    // All lanes see the same operands, only one gets valid
    for (genvar i = 0; i < vdiv_pkg::NUM_LANES; i++) begin : g_lane
        fp_div lane (
            .CLK      (CLK),
            .nRST     (nRST),
            .valid_in (lane_valid[i]),
            .ready_in (lane_ready[i]),
            .operand1 (req_a),
            .operand2 (req_b),
            .valid_out(lane_valid_out[i]),
            .ready_out(lane_ready_out[i]),
            .result   (lane_result[i])
        );
    end

    wb_arbiter arbiter (
        .CLK           (CLK),
        .nRST          (nRST),
        .lane_valid_out(lane_valid_out),
        .lane_ready_out(lane_ready_out),
        .lane_result   (lane_result),
        .lane_tag      (lane_tag),
        .res_valid     (res_valid),
        .res_ready     (res_ready),
        .res_tag       (res_tag),
        .res_data      (res_data)
    );

endmodule

//--- dv/vdiv_ref.svh
//***********************************************************
// Reference half-precision divide and the compare tasks for
// the vector divide testbench. Included inside the testbench
// module, which declares the check and error counters.
//***********************************************************
`ifndef VDIV_REF_SVH
`define VDIV_REF_SVH

// Expected quotient built from the format rules with integer math
function automatic vdiv_pkg::fp_word_t ref_div(input vdiv_pkg::fp_word_t a,
                                               input vdiv_pkg::fp_word_t b);
    vdiv_pkg::fp_word_t r;
    logic               a_zero, b_zero, a_inf, b_inf, a_nan, b_nan;
    int                 q;
    int                 m;
    int                 e;
    r.bits        = '0;
    r.fields.sign = a.fields.sign ^ b.fields.sign;
    // Exponent zero means zero or subnormal, both read as zero
    a_zero = (a.fields.exp == 0);
    b_zero = (b.fields.exp == 0);
    a_inf  = (a.fields.exp == 31) && (a.fields.mant == 0);
    b_inf  = (b.fields.exp == 31) && (b.fields.mant == 0);
    a_nan  = (a.fields.exp == 31) && (a.fields.mant != 0);
    b_nan  = (b.fields.exp == 31) && (b.fields.mant != 0);
    if (a_nan || b_nan || (a_zero && b_zero) || (a_inf && b_inf)) begin
        r.fields.exp  = 5'h1f;
        r.fields.mant = 10'h200;
        return r;
    end
    if (a_inf || b_zero) begin
        r.fields.exp = 5'h1f;
        return r;
    end
    if (a_zero || b_inf)
        return r;
    // Integer quotient of the full significands, scaled by 2^12
    q = ((1024 + int'(a.fields.mant)) * 4096) / (1024 + int'(b.fields.mant));
    e = int'(a.fields.exp) - int'(b.fields.exp) + 15;
    if (q >= 4096) begin
        m = (q / 4) + ((q / 2) % 2);
    end else begin
        m = (q / 2) + (q % 2);
        e = e - 1;
    end
    // Rounding up to 2.0 renormalizes
    if (m >= 2048) begin
        m = m / 2;
        e = e + 1;
    end
    if (e >= 31)
        r.fields.exp = 5'h1f;
    else if (e > 0) begin
        r.fields.exp  = 5'(e);
        r.fields.mant = 10'(m % 1024);
    end
    return r;
endfunction

task automatic check_data(input vdiv_pkg::fp_word_t got, input vdiv_pkg::fp_word_t want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("CHECK FAILED res_data: got %h, expected %h", got.bits, want.bits);
    end
endtask

task automatic check_tag(input logic [vdiv_pkg::TAG_WIDTH-1:0] got,
                         input logic [vdiv_pkg::TAG_WIDTH-1:0] want);
    checks++;
    if (got !== want) begin
        errors++;
        $display("CHECK FAILED res_tag: got %h, expected %h", got, want);
    end
endtask

`endif

//--- dv/vdiv_tb.sv
//***********************************************************
// Testbench for the vector divide unit. Runs directed and
// random element streams, scores each result by tag against
// the reference divide, and prints a per-test summary.
//***********************************************************
`timescale 1ns/1ns

module vdiv_tb;

    localparam int N_RANDOM   = 200;
    localparam int ELEM_BOUND = 2 * N_RANDOM + 24;
    localparam int TAGS       = 1 << vdiv_pkg::TAG_WIDTH;

    logic                           CLK;
    logic                           nRST;
    logic                           req_valid;
    logic                           req_ready;
    logic [vdiv_pkg::TAG_WIDTH-1:0] req_tag;
    vdiv_pkg::fp_word_t             req_a;
    vdiv_pkg::fp_word_t             req_b;
    logic                           res_valid;
    logic                           res_ready;
    logic [vdiv_pkg::TAG_WIDTH-1:0] res_tag;
    vdiv_pkg::fp_word_t             res_data;

    int                             seed;
    int                             checks;
    int                             errors;
    int                             err_mark;
    int                             tests;
    int                             bad_tests;
    int                             received;
    logic                           bp_on;
    logic [TAGS-1:0]                pending;
    vdiv_pkg::fp_word_t             expected [TAGS];
    logic [vdiv_pkg::TAG_WIDTH-1:0] next_tag;
    logic [vdiv_pkg::TAG_WIDTH-1:0] last_issued;
    vdiv_pkg::fp_word_t             rand_a [2*N_RANDOM];
    vdiv_pkg::fp_word_t             rand_b [2*N_RANDOM];

    `include "vdiv_ref.svh"

    vdiv_unit uut (
        .CLK      (CLK),
        .nRST     (nRST),
        .req_valid(req_valid),
        .req_ready(req_ready),
        .req_tag  (req_tag),
        .req_a    (req_a),
        .req_b    (req_b),
        .res_valid(res_valid),
        .res_ready(res_ready),
        .res_tag  (res_tag),
        .res_data (res_data)
    );

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    // Hand one element to the unit; called 1 ns after a rising edge
    task automatic issue(input vdiv_pkg::fp_word_t a, input vdiv_pkg::fp_word_t b);
        logic [vdiv_pkg::TAG_WIDTH-1:0] tag;
        tag      = next_tag;
        next_tag = next_tag + 1'b1;
        // Tag is free only once its earlier result came back
        while (pending[tag]) begin
            @(posedge CLK);
            #1;
        end
        expected[tag] = ref_div(a, b);
        pending[tag]  = 1'b1;
        req_valid = 1'b1;
        req_tag   = tag;
        req_a     = a;
        req_b     = b;
        while (!req_ready) begin
            @(posedge CLK);
            #1;
        end
        @(posedge CLK);
        #1;
        req_valid   = 1'b0;
        last_issued = tag;
    endtask

    // One element alone in the unit, waits for its result
    task automatic run_one(input logic [15:0] a, input logic [15:0] b);
        issue(a, b);
        while (pending[last_issued]) begin
            @(posedge CLK);
            #1;
        end
    endtask

    task automatic run_stream(input int first);
        int rx_start;
        rx_start = received;
        for (int i = first; i < first + N_RANDOM; i++)
            issue(rand_a[i], rand_b[i]);
        while (|pending) begin
            @(posedge CLK);
            #1;
        end
        if (received - rx_start != N_RANDOM) begin
            errors++;
            $display("Stream returned %0d results for %0d elements",
                     received - rx_start, N_RANDOM);
        end
    endtask

    task automatic report_test(input string name);
        tests++;
        if (errors != err_mark)
            bad_tests++;
        $display("%-18s %0d errors", name, errors - err_mark);
        err_mark = errors;
    endtask

    // Result transfers seen half a cycle ahead of the edge
    initial begin
        int                             n_pend;
        logic [vdiv_pkg::TAG_WIDTH-1:0] only_tag;
        forever begin
            @(negedge CLK);
            if (res_valid && res_ready) begin
                received++;
                // With one element outstanding the result must carry its tag
                n_pend   = 0;
                only_tag = '0;
                for (int t = 0; t < TAGS; t++) begin
                    if (pending[t]) begin
                        n_pend++;
                        only_tag = t[vdiv_pkg::TAG_WIDTH-1:0];
                    end
                end
                if (n_pend == 1)
                    check_tag(res_tag, only_tag);
                if (!pending[res_tag]) begin
                    errors++;
                    $display("Result came back for tag %0d with no element outstanding",
                             res_tag);
                end else begin
                    check_data(res_data, expected[res_tag]);
                    pending[res_tag] = 1'b0;
                end
            end
        end
    end

    initial begin
        logic [31:0] rnd;
        res_ready = 1'b1;
        forever begin
            @(posedge CLK);
            #1;
            rnd       = $random(seed);
            res_ready = bp_on ? rnd[0] : 1'b1;
        end
    end

    initial begin
        repeat (200 * ELEM_BOUND) @(posedge CLK);
        $display("Timeout: results did not return within %0d cycles", 200 * ELEM_BOUND);
        $display("Some tests failed");
        $finish;
    end

    initial begin
        logic [31:0] rnd;
        seed      = 32'hcc48_62f4;
        nRST      = 1'b0;
        req_valid = 1'b0;
        req_tag   = '0;
        req_a     = '0;
        req_b     = '0;
        bp_on     = 1'b0;
        pending   = '0;
        next_tag  = '0;
        checks    = 0;
        errors    = 0;
        err_mark  = 0;
        tests     = 0;
        bad_tests = 0;
        received  = 0;
        // All random operands drawn up front
        for (int i = 0; i < 2 * N_RANDOM; i++) begin
            rnd       = $random(seed);
            rand_a[i] = rnd[15:0];
            rand_b[i] = rnd[31:16];
        end
        repeat (2) @(posedge CLK);
        #1;
        nRST = 1'b1;

        run_one(16'h4600, 16'h4200);
        run_one(16'h3c00, 16'h4200);
        run_one(16'hc780, 16'h4100);
        run_one(16'h3555, 16'hb800);
        run_one(16'h7bff, 16'h3bff);
        report_test("normal divide");

        run_one(16'h7e00, 16'h3c00);
        run_one(16'h3c00, 16'hfc01);
        run_one(16'h0000, 16'h8000);
        run_one(16'h7c00, 16'hfc00);
        run_one(16'hc000, 16'h0000);
        run_one(16'hfc00, 16'h4000);
        run_one(16'h8000, 16'h4000);
        run_one(16'h4000, 16'h7c00);
        run_one(16'h0001, 16'h4000);
        run_one(16'h4000, 16'h83ff);
        report_test("special cases");

        run_one(16'h7bff, 16'h0400);
        run_one(16'hfbff, 16'h0400);
        run_one(16'h0400, 16'h7bff);
        run_one(16'h8400, 16'h7bff);
        report_test("range limits");

        run_stream(0);
        report_test("random stream");

        bp_on = 1'b1;
        run_stream(N_RANDOM);
        bp_on = 1'b0;
        report_test("back-pressure");

        $display("%0d tests, %0d with errors, %0d checks, %0d errors",
                 tests, bad_tests, checks, errors);
        if (errors == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+dv
hw/vdiv_pkg.sv
hw/mant_divider.sv
hw/fp_div.sv
hw/lane_dispatch.sv
hw/wb_arbiter.sv
hw/vdiv_unit.sv
dv/vdiv_tb.sv

//--- run.sh
#!/usr/bin/env bash
# Build and run the vector divide testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal \
    -f list.f \
    --top-module vdiv_tb \
    -o vdiv_sim

./obj_dir/vdiv_sim | tee sim.log

if grep -q "^All tests passed$" sim.log; then
    echo "Simulation result: PASS"
else
    echo "Simulation result: FAIL"
    exit 1
fi
